// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mcu_bus_top
FLIST     ?= mcu_bus_top.f
OBJ       ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM = $(OBJ)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Checks failed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf $(OBJ) $(LOG)

// File: mcu_addr_decode.sv
// MCU address decoder
// Maps the 6801 address onto ROM, internal RAM, shared RAM and on-chip ports.
// Purely combinational, selects only while the core drives a valid access

`timescale 1ns/1ps
`include "mcu_bus_config.svh"

module mcu_addr_decode (
    mcu_bus_if.decoder bus
);

    logic in_rom;
    logic in_shared;
    logic in_iram;
    logic in_port;

    assign in_rom    = bus.addr[15:14] == `MCU_ROM_TOP;
    assign in_shared = bus.addr[15:12] == `MCU_SHARED_NIB;
    assign in_iram   = (bus.addr >= `MCU_IRAM_BASE) && (bus.addr < `MCU_IRAM_END);
    assign in_port   = bus.addr < `MCU_PORT_END;

    always_comb begin
        bus.rom_cs    = 1'b0;
        bus.ram_cs    = 1'b0;
        bus.shared_cs = 1'b0;
        bus.port_cs   = 1'b0;
        // Regions are disjoint, the chain just keeps it one-hot
        if (bus.vma) begin
            if (in_rom) begin
                bus.rom_cs = 1'b1;
            end else if (in_shared) begin
                bus.shared_cs = 1'b1;
            end else if (in_iram) begin
                bus.ram_cs = 1'b1;
            end else if (in_port) begin
                bus.port_cs = 1'b1;
            end
        end
    end

endmodule

// File: mcu_bus_asserts.sv
// MCU bus glue assertions
// Bound onto the top level to watch the ROM stall, the bus lockout
// and the NMI state coming out of reset

`timescale 1ns/1ps

module mcu_bus_asserts (
    input logic clk,
    input logic rst,
    input logic mcu_cen,
    input logic rom_cs,
    input logic rom_ok,
    input logic mcu_ban,
    input logic mcu_vma,
    input logic mcu_nmi
);

    // Core must stay stalled while ROM data is outstanding
    property cen_held_during_rom_wait;
        @(posedge clk) disable iff (rst)
            (rom_cs && !rom_ok) |-> !mcu_cen;
    endproperty

    property ban_follows_vma;
        @(posedge clk) disable iff (rst)
            mcu_ban == mcu_vma;
    endproperty

    property nmi_low_after_reset;
        @(posedge clk) $fell(rst) |-> !mcu_nmi;
    endproperty

    a_cen_held : assert property (cen_held_during_rom_wait)
        else $error("mcu_cen high during a pending ROM wait");
    a_ban      : assert property (ban_follows_vma)
        else $error("mcu_ban differs from mcu_vma");
    a_nmi_rst  : assert property (nmi_low_after_reset)
        else $error("mcu_nmi high after reset");

endmodule

// File: mcu_bus_config.svh
// MCU bus glue configuration
// Address map of the 6801 sound MCU, RAM sizes and the port 6 offset
// Shared by the RTL and by the testbench reference model

`ifndef MCU_BUS_CONFIG_SVH
`define MCU_BUS_CONFIG_SVH

// Internal RAM window, end is exclusive
`define MCU_IRAM_BASE   16'h0040
`define MCU_IRAM_END    16'h0140

// On-chip ports live below this address
`define MCU_PORT_END    16'h0028
`define MCU_PORT6_OFS   8'h17

// Top address bits of shared RAM (8xxx) and ROM (Cxxx-Fxxx)
`define MCU_SHARED_NIB  4'h8
`define MCU_ROM_TOP     2'b11

`define SHARED_DEPTH    512
`define IRAM_DEPTH      256

`endif

// File: mcu_bus_if.sv
// MCU-side bus
// Carries the core address, strobes and data plus the decoded selects

`timescale 1ns/1ps

interface mcu_bus_if;
    import mcu_bus_pkg::*;

    mcu_addr_t addr;
    logic      rnw;
    logic      vma;
    byte_t     dout;
    byte_t     din;

    // Decoded selects, at most one high
    logic      rom_cs;
    logic      ram_cs;
    logic      shared_cs;
    logic      port_cs;

    modport decoder (
        input  addr, vma,
        output rom_cs, ram_cs, shared_cs, port_cs
    );

    // Port logic and shared RAM arbiter
    modport ctrl (input addr, rnw, vma, dout, port_cs, shared_cs);

    modport reader (
        input  addr, rnw, dout, ram_cs, shared_cs,
        output din
    );

    modport waiter (input rom_cs);

endinterface

// File: mcu_bus_pkg.sv
// MCU bus glue types
// Vector types for the two buses and the ROM wait state encoding

package mcu_bus_pkg;

    // One data byte, either bus
    typedef logic [7:0]  byte_t;

    // Full 6801 address
    typedef logic [15:0] mcu_addr_t;

    // 512-byte shared RAM address
    typedef logic [8:0]  shared_addr_t;

    // Offset into the 256-byte internal RAM
    typedef logic [7:0]  iram_addr_t;

    // External program ROM address
    typedef logic [13:0] rom_addr_t;

    // ROM fetch wait state machine
    typedef enum logic [1:0] {
        ROM_IDLE,
        ROM_WAIT,
        ROM_DONE
    } rom_wait_t;

endpackage

// File: mcu_bus_top.f
+incdir+.
mcu_bus_pkg.sv
mcu_bus_if.sv
mcu_addr_decode.sv
mcu_rom_wait.sv
mcu_port_ctrl.sv
shared_ram_arbiter.sv
mcu_read_mux.sv
mcu_bus_top.sv
mcu_bus_asserts.sv
tb_mcu_bus_top.sv

// File: mcu_bus_top.sv
// MCU bus glue top level
// Connects the 6801 bus of the sound MCU to its ROM, internal RAM,
// the RAM shared with the main CPU and the port 6 interrupt lines.
// The MCU core sits outside, on the mcu_* ports

`timescale 1ns/1ps

module mcu_bus_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen6,
    // Main CPU side
    input  logic [8:0]  cpu_addr,
    input  logic        cpu_wrn,
    input  logic [7:0]  cpu_dout,
    input  logic        com_cs,
    output logic [7:0]  shared_dout,
    output logic        mcu_ban,
    input  logic        mcu_nmi_set,
    output logic        mcu_irqmain,
    // MCU core bus
    output logic        mcu_nmi,
    input  logic [15:0] mcu_addr,
    input  logic        mcu_rnw,
    input  logic        mcu_vma,
    input  logic [7:0]  mcu_dout,
    output logic [7:0]  mcu_din,
    output logic        mcu_cen,
    // External program ROM
    output logic [13:0] rom_addr,
    input  logic [7:0]  rom_data,
    output logic        rom_cs,
    input  logic        rom_ok
);

    mcu_bus_if u_bus ();

    assign u_bus.addr = mcu_addr;
    assign u_bus.rnw  = mcu_rnw;
    assign u_bus.vma  = mcu_vma;
    assign u_bus.dout = mcu_dout;

    assign mcu_din  = u_bus.din;
    assign mcu_ban  = mcu_vma;
    assign rom_cs   = u_bus.rom_cs;
    assign rom_addr = mcu_addr[13:0];

    mcu_addr_decode u_decode (
        .bus (u_bus.decoder)
    );

    mcu_rom_wait u_rom_wait (
        .clk     (clk),
        .rst     (rst),
        .cen6    (cen6),
        .rom_ok  (rom_ok),
        .bus     (u_bus.waiter),
        .mcu_cen (mcu_cen)
    );

    mcu_port_ctrl u_port (
        .clk     (clk),
        .rst     (rst),
        .bus     (u_bus.ctrl),
        .mcu_cen (mcu_cen),
        .nmi_set (mcu_nmi_set),
        .irqmain (mcu_irqmain),
        .nmi     (mcu_nmi)
    );

    shared_ram_arbiter u_shared (
        .clk         (clk),
        .rst         (rst),
        .cen6        (cen6),
        .mcu_cen     (mcu_cen),
        .bus         (u_bus.ctrl),
        .cpu_addr    (cpu_addr),
        .cpu_wrn     (cpu_wrn),
        .cpu_dout    (cpu_dout),
        .com_cs      (com_cs),
        .shared_dout (shared_dout)
    );

    mcu_read_mux u_read (
        .clk      (clk),
        .cen6     (cen6),
        .mcu_cen  (mcu_cen),
        .bus      (u_bus.reader),
        .shared_q (shared_dout),
        .rom_data (rom_data)
    );

endmodule

// File: mcu_port_ctrl.sv
// MCU port 6 and NMI latch
// Port 6 bit 1 requests an interrupt on the main CPU, bit 0 low clears NMI.
// NMI is set by a rising edge on the main CPU's set strobe

`timescale 1ns/1ps
`include "mcu_bus_config.svh"

module mcu_port_ctrl (
    input  logic    clk,
    input  logic    rst,
    mcu_bus_if.ctrl bus,
    input  logic    mcu_cen,
    input  logic    nmi_set,
    output logic    irqmain,
    output logic    nmi
);
    import mcu_bus_pkg::*;

    byte_t port6;
    logic  port6_we;
    logic  nmi_set_last;
    logic  nmi_clr;

    // Writes to other ports are dropped
    assign port6_we = bus.vma & bus.port_cs & ~bus.rnw & mcu_cen
                    & (bus.addr[7:0] == `MCU_PORT6_OFS);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            port6 <= '0;
        end else if (port6_we) begin
            port6 <= bus.dout;
        end
    end

    assign irqmain = port6[1];
    assign nmi_clr = ~port6[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            nmi_set_last <= 1'b0;
            nmi          <= 1'b0;
        end else begin
            nmi_set_last <= nmi_set;
            // Clear wins over a coincident set
            if (nmi_clr) begin
                nmi <= 1'b0;
            end else if (nmi_set && !nmi_set_last) begin
                nmi <= 1'b1;
            end
        end
    end

endmodule

// File: mcu_read_mux.sv
// MCU read path
// Holds the 256-byte internal RAM at 0x0040-0x013F and picks the
// byte returned to the core from internal RAM, shared RAM or ROM

`timescale 1ns/1ps
`include "mcu_bus_config.svh"

module mcu_read_mux (
    input  logic               clk,
    input  logic               cen6,
    input  logic               mcu_cen,
    mcu_bus_if.reader          bus,
    input  mcu_bus_pkg::byte_t shared_q,
    input  mcu_bus_pkg::byte_t rom_data
);
    import mcu_bus_pkg::*;

    byte_t      iram [0:`IRAM_DEPTH-1];
    byte_t      iram_q;
    iram_addr_t iram_ofs;
    mcu_addr_t  iram_rel;
    logic       iram_we;

    // Offset from the window base, fits in 8 bits inside the window
    assign iram_rel = bus.addr - `MCU_IRAM_BASE;
    assign iram_ofs = iram_rel[7:0];

    assign iram_we = bus.ram_cs & ~bus.rnw & mcu_cen & cen6;

    always_ff @(posedge clk) begin
        if (cen6) begin
            if (iram_we) begin
                iram[iram_ofs] <= bus.dout;
            end
            iram_q <= iram[iram_ofs];
        end
    end

    // ROM is the default source
    always_comb begin
        if (bus.ram_cs) begin
            bus.din = iram_q;
        end else if (bus.shared_cs) begin
            bus.din = shared_q;
        end else begin
            bus.din = rom_data;
        end
    end

endmodule

// File: mcu_rom_wait.sv
// ROM fetch wait state
// Holds the MCU clock enable low from the start of a ROM access
// until the external ROM reports valid data with rom_ok

`timescale 1ns/1ps

module mcu_rom_wait (
    input  logic      clk,
    input  logic      rst,
    input  logic      cen6,
    input  logic      rom_ok,
    mcu_bus_if.waiter bus,
    output logic      mcu_cen
);
    import mcu_bus_pkg::*;

    rom_wait_t state;
    logic      rom_cs_last;
    logic      new_access;

    // Rising edge of the ROM select
    assign new_access = bus.rom_cs & ~rom_cs_last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= ROM_IDLE;
            rom_cs_last <= 1'b0;
        end else begin
            rom_cs_last <= bus.rom_cs;
            if (new_access) begin
                state <= ROM_WAIT;
            end else if (!bus.rom_cs) begin
                state <= ROM_IDLE;
            end else if (state == ROM_WAIT && rom_ok) begin
                state <= ROM_DONE;
            end
        end
    end

    // Core stalls on the detecting edge and for the whole wait
    assign mcu_cen = cen6 & ~new_access & (state != ROM_WAIT);

endmodule

// File: shared_ram_arbiter.sv
// Shared RAM arbiter
// 512-byte RAM seen by both the main CPU and the MCU.
// The MCU owns the port whenever vma is high, the main CPU otherwise.
// Read data is registered on cen6

`timescale 1ns/1ps
`include "mcu_bus_config.svh"

module shared_ram_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cen6,
    input  logic                      mcu_cen,
    mcu_bus_if.ctrl                   bus,
    input  mcu_bus_pkg::shared_addr_t cpu_addr,
    input  logic                      cpu_wrn,
    input  mcu_bus_pkg::byte_t        cpu_dout,
    input  logic                      com_cs,
    output mcu_bus_pkg::byte_t        shared_dout
);
    import mcu_bus_pkg::*;

    byte_t        mem [0:`SHARED_DEPTH-1];
    shared_addr_t ram_addr;
    byte_t        ram_data;
    logic         ram_we;
    logic         mcu_we;
    logic         cpu_we;

    assign mcu_we = bus.shared_cs & ~bus.rnw & mcu_cen;
    // Main CPU is locked out for the whole MCU access
    assign cpu_we = com_cs & ~cpu_wrn;

    always_comb begin
        if (bus.vma) begin
            ram_addr = bus.addr[8:0];
            ram_data = bus.dout;
            ram_we   = mcu_we;
        end else begin
            ram_addr = cpu_addr;
            ram_data = cpu_dout;
            ram_we   = cpu_we;
        end
    end

    // No stores while reset is held
    always_ff @(posedge clk) begin
        if (cen6) begin
            if (ram_we && !rst) begin
                mem[ram_addr] <= ram_data;
            end
            shared_dout <= mem[ram_addr];
        end
    end

endmodule

// File: tb_mcu_bus_top.sv
// Testbench for the MCU bus glue
// Plays the 6801 core, the main CPU and the external ROM, and checks the
// shared RAM, internal RAM, port 6, NMI latch and ROM wait against models

`timescale 1ns/1ps
`include "mcu_bus_config.svh"

module tb_mcu_bus_top;

    logic        clk, rst, cen6;
    logic [8:0]  cpu_addr;
    logic        cpu_wrn, com_cs;
    logic [7:0]  cpu_dout, shared_dout;
    logic        mcu_ban, mcu_nmi_set, mcu_irqmain, mcu_nmi;
    logic [15:0] mcu_addr;
    logic        mcu_rnw, mcu_vma;
    logic [7:0]  mcu_dout, mcu_din;
    logic        mcu_cen;
    logic [13:0] rom_addr;
    logic [7:0]  rom_data;
    logic        rom_cs, rom_ok;

    // Reference models
    logic [7:0]  shared_m [0:`SHARED_DEPTH-1];
    logic [7:0]  iram_m [0:`IRAM_DEPTH-1];
    logic [7:0]  port6_m;
    logic        nmi_m;

    logic [31:0] rng;
    logic [31:0] rom_rng;
    int          errors, checks, tests, test_base;

    mcu_bus_top uut (.*);

    bind mcu_bus_top mcu_bus_asserts u_asserts (
        .clk(clk), .rst(rst), .mcu_cen(mcu_cen), .rom_cs(rom_cs), .rom_ok(rom_ok),
        .mcu_ban(mcu_ban), .mcu_vma(mcu_vma), .mcu_nmi(mcu_nmi)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // cen6 high on every other cycle
    initial begin
        cen6 = 1'b0;
        forever begin
            @(posedge clk);
            #1 cen6 = ~cen6;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function logic [31:0] rand_word();
        rng = lcg_next(rng);
        return rng;
    endfunction

    // ROM contents as a hash of the address
    function automatic logic [7:0] rom_byte(input logic [13:0] a);
        logic [31:0] h;
        h = lcg_next({18'h0, a} ^ 32'd91812);
        return h[23:16];
    endfunction

    // ROM responder with a random latency on rom_ok
    initial begin
        logic        cs_now;
        logic        busy;
        logic [13:0] a;
        int          cnt;
        rom_ok   = 1'b0;
        rom_data = 8'h00;
        rom_rng  = 32'd91812;
        busy     = 1'b0;
        cnt      = 0;
        forever begin
            @(posedge clk);
            cs_now = rom_cs;
            a      = rom_addr;
            #1;
            if (!cs_now) begin
                rom_ok = 1'b0;
                busy   = 1'b0;
            end else if (!busy) begin
                busy     = 1'b1;
                rom_rng  = lcg_next(rom_rng);
                cnt      = int'(rom_rng[18:16]);
                rom_data = rom_byte(a);
            end else if (cnt > 0) begin
                cnt = cnt - 1;
            end else begin
                rom_ok = 1'b1;
            end
        end
    end

    task automatic timeout_fail(input string what);
        $display("Timeout waiting for %s", what);
        $display("Checks failed");
        $finish;
    endtask

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%02h expected 0x%02h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cond(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("Test %0d %s: %0d errors", tests, name, errors - test_base);
        test_base = errors;
    endtask

    task automatic to_drive();
        @(posedge clk);
        #1;
    endtask

    // Wait two cen6 edges and stop at the falling clock edge to sample
    task automatic settle();
        int i;
        int cnt;
        cnt = 0;
        for (i = 0; i < 200 && cnt < 2; i++) begin
            @(posedge clk);
            if (cen6) cnt++;
        end
        if (cnt < 2) timeout_fail("cen6");
        @(negedge clk);
    endtask

    task automatic drive_mcu(input logic [15:0] a, input logic r, input logic v,
                             input logic [7:0] d);
        mcu_addr = a;
        mcu_rnw  = r;
        mcu_vma  = v;
        mcu_dout = d;
    endtask

    task automatic drive_cpu(input logic [8:0] a, input logic cs, input logic wrn,
                             input logic [7:0] d);
        cpu_addr = a;
        com_cs   = cs;
        cpu_wrn  = wrn;
        cpu_dout = d;
    endtask

    task automatic mcu_cycle(input logic [15:0] a, input logic r, input logic [7:0] d);
        to_drive();
        drive_cpu(9'h0, 1'b0, 1'b1, 8'h00);
        drive_mcu(a, r, 1'b1, d);
        settle();
    endtask

    task automatic cpu_read_check(input logic [8:0] a);
        to_drive();
        drive_mcu(16'h0, 1'b1, 1'b0, 8'h00);
        drive_cpu(a, 1'b0, 1'b1, 8'h00);
        settle();
        check_byte("shared_dout", shared_dout, shared_m[a]);
    endtask

    task automatic rom_read(input logic [13:0] low);
        logic [15:0] a;
        logic        ok_seen;
        logic        released;
        int          i;
        a        = {`MCU_ROM_TOP, low};
        ok_seen  = 1'b0;
        released = 1'b0;
        to_drive();
        drive_mcu(a, 1'b1, 1'b1, 8'h00);
        for (i = 0; i < 200 && !released; i++) begin
            @(negedge clk);
            if (mcu_cen) released = 1'b1;
            else if (rom_ok) ok_seen = 1'b1;
        end
        if (!released) timeout_fail("mcu_cen after ROM read");
        check_cond(ok_seen, "mcu_cen returned before rom_ok arrived");
        check_byte("rom_cs", {7'h0, rom_cs}, 8'h01);
        check_byte("rom_addr", rom_addr[7:0], low[7:0]);
        check_byte("rom_addr_hi", {2'b00, rom_addr[13:8]}, {2'b00, low[13:8]});
        check_byte("mcu_din", mcu_din, rom_byte(low));
        to_drive();
        drive_mcu(16'h0, 1'b1, 1'b0, 8'h00);
        repeat (2) @(posedge clk);
    endtask

    initial begin
        logic [31:0] r;
        logic [8:0]  ofs;
        logic [7:0]  d;
        logic [15:0] a;
        logic [7:0]  wr_ofs [0:23];
        int          i;
        rng = 32'd91812;
        errors = 0;
        checks = 0;
        tests = 0;
        test_base = 0;
        port6_m = 8'h00;
        nmi_m = 1'b0;
        rst = 1'b1;
        mcu_nmi_set = 1'b0;
        drive_cpu(9'h0, 1'b0, 1'b1, 8'h00);
        drive_mcu(16'h0, 1'b1, 1'b0, 8'h00);
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        for (i = 0; i < 16; i++) begin
            r = rand_word();
            ofs = r[24:16];
            d = r[15:8];
            to_drive();
            drive_mcu(16'h0, 1'b1, 1'b0, 8'h00);
            drive_cpu(ofs, 1'b1, 1'b0, d);
            settle();
            shared_m[ofs] = d;
            mcu_cycle({`MCU_SHARED_NIB, 3'b000, ofs}, 1'b1, 8'h00);
            check_byte("mcu_din", mcu_din, shared_m[ofs]);
        end
        end_test("cpu write, mcu read of shared RAM");

        for (i = 0; i < 16; i++) begin
            r = rand_word();
            ofs = r[24:16];
            d = r[15:8];
            mcu_cycle({`MCU_SHARED_NIB, 3'b000, ofs}, 1'b0, d);
            shared_m[ofs] = d;
            cpu_read_check(ofs);
            // Main CPU write while the MCU owns the bus
            to_drive();
            drive_mcu({`MCU_SHARED_NIB, 3'b000, ~ofs}, 1'b1, 1'b1, 8'h00);
            drive_cpu(ofs, 1'b1, 1'b0, ~d);
            settle();
            cpu_read_check(ofs);
        end
        end_test("mcu write, cpu lockout on shared RAM");

        for (i = 0; i < 24; i++) begin
            r = rand_word();
            d = r[15:8];
            wr_ofs[i] = r[23:16];
            a = `MCU_IRAM_BASE + {8'h00, r[23:16]};
            mcu_cycle(a, 1'b0, d);
            iram_m[r[23:16]] = d;
        end
        // Read back after all writes so aliased offsets show up
        for (i = 0; i < 24; i++) begin
            a = `MCU_IRAM_BASE + {8'h00, wr_ofs[i]};
            mcu_cycle(a, 1'b1, 8'h00);
            check_byte("mcu_din", mcu_din, iram_m[wr_ofs[i]]);
        end
        end_test("internal RAM");

        for (i = 0; i < 12; i++) begin
            r = rand_word();
            d = r[15:8];
            if (r[31]) begin
                a = {8'h00, `MCU_PORT6_OFS};
                port6_m = d;
            end else begin
                a = {11'h0, r[20:16]};
                if (a[7:0] == `MCU_PORT6_OFS) a = 16'h0020;
            end
            mcu_cycle(a, 1'b0, d);
            check_byte("mcu_irqmain", {7'h0, mcu_irqmain}, {7'h0, port6_m[1]});
        end
        end_test("port 6 register");

        mcu_cycle({8'h00, `MCU_PORT6_OFS}, 1'b0, 8'h01);
        port6_m = 8'h01;
        to_drive();
        mcu_nmi_set = 1'b1;
        for (i = 0; i < 200 && !mcu_nmi; i++) begin
            @(negedge clk);
        end
        if (!mcu_nmi) timeout_fail("mcu_nmi");
        if (port6_m[0]) nmi_m = 1'b1;
        to_drive();
        mcu_nmi_set = 1'b0;
        mcu_cycle({8'h00, `MCU_PORT6_OFS}, 1'b0, 8'h00);
        port6_m = 8'h00;
        // Port 6 bit 0 low clears the latch
        if (!port6_m[0]) nmi_m = 1'b0;
        check_byte("mcu_nmi", {7'h0, mcu_nmi}, {7'h0, nmi_m});
        to_drive();
        mcu_nmi_set = 1'b1;
        // Clear must win over the new rising edge on every cycle
        for (i = 0; i < 6; i++) begin
            @(negedge clk);
            check_byte("mcu_nmi", {7'h0, mcu_nmi}, {7'h0, nmi_m});
        end
        to_drive();
        mcu_nmi_set = 1'b0;
        end_test("NMI latch");

        for (i = 0; i < 12; i++) begin
            r = rand_word();
            rom_read(r[29:16]);
        end
        end_test("ROM wait state");

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
